// File: all.f
logic/soc_mem_pkg.sv
logic/bus_fabric.sv
logic/ram_ready_delay.sv
logic/uart_prog_loader.sv
logic/ram_block.sv
logic/soc_mem_top.sv
tb/tb_soc_mem.sv

// File: logic/bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n,
  input  wire soc_mem_pkg::mem_req_t req_i,
  input  wire logic                 ram_ready_i,
  input  wire soc_mem_pkg::word_t    ram_rdata_i,
  output soc_mem_pkg::mem_rsp_t     rsp_o,
  output logic                      ram_sel_o,
  output soc_mem_pkg::ram_wr_t      ram_wr_o,
  output logic                      ram_rd_en_o
);

  import soc_mem_pkg::*;

  logic        ram_hit;
  logic        tlo_hit;
  logic        thi_hit;
  logic        unm_hit;
  logic        unm_ready_q;
  logic [63:0] timer_q;

  assign ram_hit = req_i.valid && ((req_i.addr & ~RAM_MASK) == RAM_BASE);
  assign tlo_hit = req_i.valid && (req_i.addr == TIMER_LO_ADDR);
  assign thi_hit = req_i.valid && (req_i.addr == TIMER_HI_ADDR);
  assign unm_hit = req_i.valid && !ram_hit && !tlo_hit && !thi_hit;

  assign ram_sel_o       = ram_hit;
  assign ram_wr_o.strobe = ram_hit ? req_i.wstrb : '0;
  assign ram_wr_o.index  = req_i.addr[11:2];
  assign ram_wr_o.data   = req_i.wdata;
  assign ram_rd_en_o     = ram_hit && (req_i.wstrb == '0);

  // unmapped access answers one cycle late so the bus never hangs
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      unm_ready_q <= 1'b0;
    end else begin
      unm_ready_q <= unm_hit && !unm_ready_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  assign rsp_o.ready = ram_ready_i | tlo_hit | thi_hit | unm_ready_q;

  always_comb begin
    if (tlo_hit) begin
      rsp_o.rdata = timer_q[31:0];
    end else if (thi_hit) begin
      rsp_o.rdata = timer_q[63:32];
    end else if (unm_hit) begin
      rsp_o.rdata = '0;
    end else begin
      rsp_o.rdata = ram_rdata_i; // registered RAM word
    end
  end

  a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n)
    rsp_o.ready |-> req_i.valid);

endmodule

`default_nettype wire

// File: logic/ram_block.sv
`timescale 1ns/1ps
`default_nettype none

module ram_block (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n,
  input  wire soc_mem_pkg::ram_wr_t  wr_i,
  input  wire logic                 rd_en_i,
  input  wire soc_mem_pkg::ram_idx_t rd_index_i,
  input  wire logic                 prog_rx_i,
  output soc_mem_pkg::word_t        rd_data_o,
  output logic                      sys_rst_n_o,
  output logic                      prog_mode_led_o
);

  import soc_mem_pkg::*;

  word_t   mem [RAM_WORDS];
  word_t   rd_data_q;
  ram_wr_t ldr_wr;
  ram_wr_t wr;

  uart_prog_loader i_uart_prog_loader (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .rx_i            (prog_rx_i),
    .wr_o            (ldr_wr),
    .sys_rst_n_o     (sys_rst_n_o),
    .prog_mode_led_o (prog_mode_led_o)
  );

  assign wr = (ldr_wr.strobe != '0) ? ldr_wr : wr_i; // loader wins the port

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (wr.strobe[b]) begin
        mem[wr.index][8*b +: 8] <= wr.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_q <= mem[rd_index_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// File: logic/ram_ready_delay.sv
`timescale 1ns/1ps
`default_nettype none

module ram_ready_delay (
  input  wire logic clk_i,
  input  wire logic rst_n,
  input  wire logic sel_i,
  input  wire logic ready_i,
  output logic      ready_o
);

  import soc_mem_pkg::*;

  logic                   start_q;
  logic [RAM_LATENCY-1:0] shift_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      shift_q <= '0;
    end else begin
      start_q <= sel_i && !ready_i; // pending RAM request
      if (sel_i && ready_i) begin
        shift_q <= '0; // handshake done
      end else begin
        shift_q <= {shift_q[RAM_LATENCY-2:0], start_q};
      end
    end
  end

  assign ready_o = shift_q[RAM_LATENCY-1];

  a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
    ready_o |=> !ready_o);

endmodule

`default_nettype wire

// File: logic/soc_mem_pkg.sv
`default_nettype none

package soc_mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [9:0]  ram_idx_t;
  typedef logic [7:0]  byte_t;

  typedef struct packed {
    logic  valid;
    strb_t wstrb;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    strb_t    strobe;
    ram_idx_t index;
    word_t    data;
  } ram_wr_t;

  localparam addr_t RAM_BASE      = 32'h4000_0000;
  localparam addr_t RAM_MASK      = 32'h000f_ffff;
  localparam addr_t TIMER_LO_ADDR = 32'h3000_0000;
  localparam addr_t TIMER_HI_ADDR = 32'h3000_0004;

  localparam int unsigned RAM_WORDS    = 1024;
  localparam int unsigned RAM_LATENCY  = 4; // cycles in the ready shifter
  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
  localparam byte_t       PROG_MAGIC   = 8'hA5;

  typedef enum logic [1:0] {IDLE, COUNT, DATA, DONE} loader_state_e;

endpackage

`default_nettype wire

// File: logic/soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n,
  input  wire soc_mem_pkg::mem_req_t req_i,
  input  wire logic                 prog_rx_i,
  output soc_mem_pkg::mem_rsp_t     rsp_o,
  output logic                      sys_rst_n_o,
  output logic                      prog_mode_led_o
);

  import soc_mem_pkg::*;

  logic    ldr_rst_n;
  logic    sys_rst_n;
  logic    ram_sel;
  logic    ram_ready;
  logic    ram_rd_en;
  ram_wr_t ram_wr;
  word_t   ram_rdata;

  assign sys_rst_n   = rst_n & ldr_rst_n; // loader holds the system while it programs
  assign sys_rst_n_o = sys_rst_n;

  bus_fabric i_bus_fabric (
    .clk_i       (clk_i),
    .rst_n       (sys_rst_n),
    .req_i       (req_i),
    .ram_ready_i (ram_ready),
    .ram_rdata_i (ram_rdata),
    .rsp_o       (rsp_o),
    .ram_sel_o   (ram_sel),
    .ram_wr_o    (ram_wr),
    .ram_rd_en_o (ram_rd_en)
  );

  ram_ready_delay i_ram_ready_delay (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .sel_i   (ram_sel),
    .ready_i (rsp_o.ready),
    .ready_o (ram_ready)
  );

  ram_block i_ram_block (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .wr_i            (ram_wr),
    .rd_en_i         (ram_rd_en),
    .rd_index_i      (ram_wr.index), // same word index for read and write
    .prog_rx_i       (prog_rx_i),
    .rd_data_o       (ram_rdata),
    .sys_rst_n_o     (ldr_rst_n),
    .prog_mode_led_o (prog_mode_led_o)
  );

endmodule

`default_nettype wire

// File: logic/uart_prog_loader.sv
`timescale 1ns/1ps
`default_nettype none

module uart_prog_loader (
  input  wire logic            clk_i,
  input  wire logic            rst_n,
  input  wire logic            rx_i,
  output soc_mem_pkg::ram_wr_t wr_o,
  output logic                 sys_rst_n_o,
  output logic                 prog_mode_led_o
);

  import soc_mem_pkg::*;

  logic [1:0]            rx_sync_q;
  logic                  rx_s;
  logic                  rx_busy_q;
  logic [BAUD_CNT_W-1:0] clk_cnt_q;
  logic [3:0]            bit_cnt_q;
  byte_t                 shift_q;
  logic                  byte_vld_q;

  loader_state_e state_q;
  byte_t         words_left_q;
  logic [1:0]    byte_idx_q;
  ram_idx_t      idx_q;
  word_t         word_q;
  word_t         next_word;
  strb_t         wr_strb_q;
  ram_idx_t      wr_idx_q;
  word_t         wr_data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_sync_q <= 2'b11; // line idles high
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
    end
  end

  assign rx_s = rx_sync_q[1];

  // bit 0 is the start bit, 1..8 data, 9 the stop bit
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_busy_q  <= 1'b0;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      byte_vld_q <= 1'b0;
    end else begin
      byte_vld_q <= 1'b0;
      if (!rx_busy_q) begin
        if (!rx_s) begin
          rx_busy_q <= 1'b1;
          clk_cnt_q <= BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1); // aim at mid-bit
          bit_cnt_q <= '0;
        end
      end else if (clk_cnt_q != '0) begin
        clk_cnt_q <= clk_cnt_q - 1'b1;
      end else begin
        clk_cnt_q <= BAUD_CNT_W'(CLKS_PER_BIT - 1);
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd0) begin
          rx_busy_q <= !rx_s; // glitch, not a start bit
        end else if (bit_cnt_q == 4'd9) begin
          rx_busy_q  <= 1'b0;
          byte_vld_q <= rx_s; // drop bytes with a bad stop bit
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_busy_q && clk_cnt_q == '0 && bit_cnt_q != 4'd0 && bit_cnt_q != 4'd9) begin
      shift_q <= {rx_s, shift_q[7:1]}; // lsb first
    end
  end

  assign next_word = {shift_q, word_q[31:8]};

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      words_left_q <= '0;
      byte_idx_q   <= '0;
      idx_q        <= '0;
      wr_strb_q    <= '0;
    end else begin
      wr_strb_q <= '0;
      case (state_q)
        IDLE: begin
          if (byte_vld_q && shift_q == PROG_MAGIC) begin
            state_q <= COUNT;
          end
        end
        COUNT: begin
          if (byte_vld_q) begin
            words_left_q <= shift_q;
            byte_idx_q   <= '0;
            idx_q        <= '0;
            state_q      <= (shift_q == '0) ? DONE : DATA;
          end
        end
        DATA: begin
          if (byte_vld_q) begin
            byte_idx_q <= byte_idx_q + 2'd1;
            if (byte_idx_q == 2'd3) begin
              wr_strb_q    <= 4'hf;
              idx_q        <= idx_q + 1'b1;
              words_left_q <= words_left_q - 1'b1;
              if (words_left_q == 8'd1) begin
                state_q <= DONE;
              end
            end
          end
        end
        DONE: state_q <= IDLE; // last write lands here
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == DATA && byte_vld_q) begin
      word_q <= next_word;
      if (byte_idx_q == 2'd3) begin
        wr_idx_q  <= idx_q;
        wr_data_q <= next_word;
      end
    end
  end

  assign wr_o.strobe     = wr_strb_q;
  assign wr_o.index      = wr_idx_q;
  assign wr_o.data       = wr_data_q;
  assign prog_mode_led_o = (state_q != IDLE);
  assign sys_rst_n_o     = (state_q == IDLE);

  a_no_write_idle: assert property (@(posedge clk_i) disable iff (!rst_n)
    (wr_strb_q != '0) |-> (state_q != IDLE));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the result.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_mem -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_soc_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: tb/soc_mem_vectors.txt
# W address strobe data | R address expected_data
# T 1 = timer low word must rise, 0 = must have dropped | U byte_count bytes...
W 40000000 f 01234567
W 40000004 f 89abcdef
R 40000000 01234567
R 40000004 89abcdef
W 40000008 f 11223344
W 40000008 3 aaaabbbb
R 40000008 1122bbbb
W 4000000c f 55667788
W 4000000c c 9999cccc
R 4000000c 99997788
W 40000010 f 00000000
W 40000010 5 a1b2c3d4
R 40000010 00b200d4
T 1
R 30000004 00000000
W 30000000 f deadbeef
T 1
R 12340000 00000000
W 50000000 f cafef00d
R 40100000 00000000
T 1
U 0a a5 02 11 22 33 44 55 66 77 88
T 0
R 40000000 44332211
R 40000004 88776655
R 40000008 1122bbbb
T 1

// File: tb/tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem;

  import soc_mem_pkg::*;

  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned BUS_WAIT_MAX = 32; // cycles allowed for one response
  localparam int unsigned BIT_NS       = CLK_PERIOD * CLKS_PER_BIT;

  logic     clk_i;
  logic     rst_n;
  mem_req_t req;
  logic     prog_rx;
  mem_rsp_t rsp;
  logic     sys_rst_n;
  logic     prog_led;

  logic [7:0] op_kind [$];
  addr_t      op_addr [$];
  word_t      op_arg  [$]; // strobe, timer direction or byte count
  word_t      op_data [$];
  byte_t      uart_q  [$];

  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  int unsigned err_cnt;
  int unsigned pass_cnt;
  word_t       last_timer;

  soc_mem_top i_soc_mem_top (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .req_i           (req),
    .prog_rx_i       (prog_rx),
    .rsp_o           (rsp),
    .sys_rst_n_o     (sys_rst_n),
    .prog_mode_led_o (prog_led)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  task automatic expect_level(input string name, input logic got, input logic exp,
                              inout bit ok);
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      ok = 1'b0;
    end
  endtask

  task automatic compare_word(input word_t got, input word_t exp, inout bit ok);
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t rsp_o.rdata got %h expected %h", $time, got, exp);
      ok = 1'b0;
    end
  endtask

  task automatic read_vectors();
    int         fd;
    int         n;
    logic [7:0] op;
    string      rest;
    addr_t      a;
    word_t      s;
    word_t      d;
    byte_t      b;
    fd = $fopen("tb/soc_mem_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file tb/soc_mem_vectors.txt");
      err_cnt++;
    end else begin
      while ($fscanf(fd, " %c", op) == 1) begin
        a = '0;
        s = '0;
        d = '0;
        case (op)
          "#": n = $fgets(rest, fd); // column notes
          "W": n = $fscanf(fd, "%h %h %h", a, s, d);
          "R": n = $fscanf(fd, "%h %h", a, d);
          "T": begin
            n = $fscanf(fd, "%h", s);
            a = TIMER_LO_ADDR;
          end
          "U": begin
            n = $fscanf(fd, "%h", s);
            for (int i = 0; i < int'(s); i++) begin
              n = $fscanf(fd, "%h", b);
              uart_q.push_back(b);
            end
          end
          default: begin
            $display("unknown opcode %c in the vector file", op);
            err_cnt++;
          end
        endcase
        if (op inside {"W", "R", "T", "U"}) begin
          op_kind.push_back(op);
          op_addr.push_back(a);
          op_arg.push_back(s);
          op_data.push_back(d);
        end
      end
      $fclose(fd);
    end
  endtask

  // called 1 ns after a rising edge, returns at the same phase
  task automatic bus_access(input addr_t addr, input strb_t strb, input word_t wdata,
                            output word_t rdata, inout bit ok);
    int unsigned waited;
    waited = 0;
    req.valid = 1'b1;
    req.wstrb = strb;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge clk_i);
    while (!rsp.ready && waited < BUS_WAIT_MAX) begin
      @(negedge clk_i);
      waited++;
    end
    assert (rsp.ready) else begin
      $display("bus timeout: no ready for address %h after %0d cycles", addr, waited);
      ok = 1'b0;
    end
    rdata = rsp.rdata;
    @(posedge clk_i); // handshake edge
    #1;
    req = '0;
  endtask

  task automatic uart_send(input byte_t data, input bit in_frame, inout bit ok);
    prog_rx = 1'b0;
    #(BIT_NS);
    if (in_frame) begin
      expect_level("prog_mode_led_o", prog_led, 1'b1, ok);
      expect_level("sys_rst_n_o", sys_rst_n, 1'b0, ok);
    end
    for (int i = 0; i < 8; i++) begin
      prog_rx = data[i]; // lsb first
      #(BIT_NS);
    end
    prog_rx = 1'b1;
    #(BIT_NS);
  endtask

  task automatic wait_loader_idle(inout bit ok);
    int unsigned waited;
    waited = 0;
    while (sys_rst_n !== 1'b1 && waited < 16) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    assert (sys_rst_n === 1'b1) else begin
      $display("loader still holds the system reset 16 cycles after the frame");
      ok = 1'b0;
    end
    expect_level("prog_mode_led_o", prog_led, 1'b0, ok);
  endtask

  initial begin
    int unsigned bus_ops;
    int unsigned ubase;
    word_t       rdata;
    bit          ok;
    rst_n      = 1'b0;
    req        = '0;
    prog_rx    = 1'b1;
    last_timer = '0;
    bus_ops    = 0;
    ubase      = 0;
    void'($urandom(32'h70c2));
    read_vectors();
    foreach (op_kind[k]) begin
      if (op_kind[k] != "U") bus_ops++;
    end
    cycle_limit = uart_q.size() * 10 * CLKS_PER_BIT + 64 * bus_ops + 16;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    for (int k = 0; k < op_kind.size(); k++) begin
      ok = 1'b1;
      repeat ($urandom_range(3, 1)) @(posedge clk_i); // idle gap
      #1;
      case (op_kind[k])
        "W": bus_access(op_addr[k], strb_t'(op_arg[k]), op_data[k], rdata, ok);
        "R": begin
          bus_access(op_addr[k], '0, '0, rdata, ok);
          compare_word(rdata, op_data[k], ok);
        end
        "T": begin
          bus_access(op_addr[k], '0, '0, rdata, ok);
          if (op_arg[k] != '0) begin
            assert (rdata > last_timer) else begin
              $display("CHECK FAILED t=%0t rsp_o.rdata got %h expected above %h",
                       $time, rdata, last_timer);
              ok = 1'b0;
            end
          end else begin
            assert (rdata < last_timer) else begin
              $display("CHECK FAILED t=%0t rsp_o.rdata got %h expected below %h",
                       $time, rdata, last_timer);
              ok = 1'b0;
            end
          end
          last_timer = rdata;
        end
        default: begin
          expect_level("prog_mode_led_o", prog_led, 1'b0, ok);
          expect_level("sys_rst_n_o", sys_rst_n, 1'b1, ok);
          for (int i = 0; i < int'(op_arg[k]); i++) begin
            uart_send(uart_q[ubase + i], i != 0, ok);
          end
          ubase += op_arg[k];
          wait_loader_idle(ok);
        end
      endcase
      if (ok) begin
        pass_cnt++;
      end else begin
        err_cnt++;
      end
      $display("test %0d %c %h: %s", k, op_kind[k], op_addr[k], ok ? "ok" : "FAILED");
    end

    $display("tests run %0d, passed %0d, failed %0d", op_kind.size(), pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
